/* design/bypass_ctrl.sv */
module bypass_ctrl (
	input  logic                 clk,
	input  logic                 rst_n,
	input  decode_pkg::rf_read_t rf_rd,      // ports read by instr in decode
	input  decode_pkg::wb_ctrl_t wb_id_ex,   // writer one ahead
	input  decode_pkg::wb_ctrl_t wb_ex_dm,   // writer two ahead
	output decode_pkg::byp_t     byp         // forwarding selects for EX
);

	decode_pkg::byp_t byp_nxt;

	// r0 is hardwired so a match on it means nothing
	function automatic logic hit(input decode_pkg::wb_ctrl_t w,
		input logic [decode_pkg::REG_W-1:0] addr);
		hit = w.rf_we && (w.dst == addr) && (addr != decode_pkg::ZERO_REG);
	endfunction

	always_comb begin
		byp_nxt.byp0_ex = hit(wb_id_ex, rf_rd.p0_addr);
		byp_nxt.byp0_dm = hit(wb_ex_dm, rf_rd.p0_addr);  // ADDZ knock-down already applied
		byp_nxt.byp1_ex = hit(wb_id_ex, rf_rd.p1_addr);
		byp_nxt.byp1_dm = hit(wb_ex_dm, rf_rd.p1_addr);
	end

	// these sit alongside the other ID_EX flops
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			byp <= '0;
		end else begin
			byp <= byp_nxt;
		end
	end

endmodule

/* design/decode_pkg.sv */
package decode_pkg;

	////////////////////
	// widths and fixed registers
	////////////////////
	localparam int INSTR_W = 48;                       // full instruction word
	localparam int OPC_W   = 6;                        // opcode sits at [41:36]
	localparam int REG_W   = 6;                        // register address width
	localparam int IMM_W   = 15;                       // low bits carried as immediate

	localparam logic [REG_W-1:0] LINK_REG = 6'd15;     // JAL return address goes here
	localparam logic [REG_W-1:0] ZERO_REG = 6'd0;      // reads as zero, never bypassed

	////////////////////
	// opcodes
	////////////////////
	localparam logic [OPC_W-1:0] OPC_ADD  = 6'b000000;
	localparam logic [OPC_W-1:0] OPC_ADDZ = 6'b000001; // add only if zero flag set
	localparam logic [OPC_W-1:0] OPC_SUB  = 6'b000010;
	localparam logic [OPC_W-1:0] OPC_AND  = 6'b000011;
	localparam logic [OPC_W-1:0] OPC_NOR  = 6'b000100;
	localparam logic [OPC_W-1:0] OPC_SLL  = 6'b000101;
	localparam logic [OPC_W-1:0] OPC_SRL  = 6'b000110;
	localparam logic [OPC_W-1:0] OPC_SRA  = 6'b000111;
	localparam logic [OPC_W-1:0] OPC_LW   = 6'b001000;
	localparam logic [OPC_W-1:0] OPC_SW   = 6'b001001;
	localparam logic [OPC_W-1:0] OPC_LHB  = 6'b001010;
	localparam logic [OPC_W-1:0] OPC_LLB  = 6'b001011;
	localparam logic [OPC_W-1:0] OPC_BR   = 6'b001100;
	localparam logic [OPC_W-1:0] OPC_JAL  = 6'b001101;
	localparam logic [OPC_W-1:0] OPC_JR   = 6'b001110;
	localparam logic [OPC_W-1:0] OPC_HLT  = 6'b001111;
	localparam logic [OPC_W-1:0] OPC_ADDI = 6'b011000; // 6 bit zero extended immediate

	localparam logic [INSTR_W-1:0] RESET_INSTR = {6'b0, OPC_LLB, 36'b0}; // LLB R0 #0

	////////////////////
	// datapath selects
	////////////////////
	typedef enum logic [4:0] {
		ADD = 5'd0,
		SUB = 5'd1,
		AND = 5'd2,
		NOR = 5'd3,
		SLL = 5'd4,
		SRL = 5'd5,
		SRA = 5'd6,
		LHB = 5'd7                                     // merge imm into upper byte
	} alu_func_t;

	typedef enum logic [2:0] {
		RF2SRC0       = 3'd0,                          // register port 0
		IMM2SRC0      = 3'd1,                          // sign extended address offset
		IMM_BR2SRC0   = 3'd2,                          // branch displacement
		IMM_JMP2SRC0  = 3'd3,                          // jump displacement
		IMM2SRC0_6BZE = 3'd4                           // 6 bit zero extended imm
	} src0sel_t;

	typedef enum logic [1:0] {
		RF2SRC1  = 2'd0,                               // register port 1
		IMM2SRC1 = 2'd1,                               // byte immediate for LHB/LLB
		NPC2SRC1 = 2'd2                                // next pc for flow change
	} src1sel_t;

	////////////////////
	// instruction views
	////////////////////
	typedef struct packed {
		logic [5:0]       rsvd_hi;
		logic [OPC_W-1:0] opcode;
		logic [35:18]     rsvd_mid;
		logic [REG_W-1:0] dst;                         // [17:12]
		logic [REG_W-1:0] p1;                          // [11:6]
		logic [REG_W-1:0] p0;                          // [5:0]
	} r_form_t;

	typedef struct packed {
		logic [5:0]       rsvd_hi;
		logic [OPC_W-1:0] opcode;
		logic             rsvd_35;
		logic [2:0]       cc;                          // [34:32] branch condition
		logic [31:15]     rsvd_mid;
		logic [IMM_W-1:0] offset;                      // [14:0] immediate / displacement
	} b_form_t;

	typedef union packed {
		r_form_t r;
		b_form_t b;
	} instr_t;

	////////////////////
	// control bundles
	////////////////////
	typedef struct packed {
		logic             re0;
		logic             re1;
		logic [REG_W-1:0] p0_addr;
		logic [REG_W-1:0] p1_addr;
	} rf_read_t;

	typedef struct packed {
		logic             br_instr;
		logic             jmp_imm;
		logic             jmp_reg;
		alu_func_t        alu_func;
		src0sel_t         src0sel;
		src1sel_t         src1sel;
		logic             clk_z;                       // update zero flag
		logic             clk_nv;                      // update neg/ov flags
		logic [2:0]       cc;
		logic [IMM_W-1:0] imm;
	} ex_ctrl_t;

	typedef struct packed {
		logic dm_re;
		logic dm_we;
		logic jmp_imm;                                 // JAL steers dst mux
	} dm_ctrl_t;

	typedef struct packed {
		logic             rf_we;
		logic [REG_W-1:0] dst;
	} wb_ctrl_t;

	typedef struct packed {
		logic byp0_ex;
		logic byp0_dm;
		logic byp1_ex;
		logic byp1_dm;
	} byp_t;

	typedef struct packed {
		ex_ctrl_t ex;
		logic     dm_re;
		logic     dm_we;
		wb_ctrl_t wb;
		logic     hlt;
		logic     cond_ex;                             // ADDZ style conditional write
	} id_ctrl_t;

endpackage

/* design/hazard_unit.sv */
module hazard_unit (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 flow_change_id_ex, // taken branch/jump in EX
	input  decode_pkg::rf_read_t rf_rd,             // reads of instr in decode
	input  decode_pkg::wb_ctrl_t wb_id_ex,          // dst of instr in EX
	input  logic                 dm_re_id_ex,       // instr in EX is a load
	input  logic                 hlt_id_ex,
	input  logic                 hlt_ex_dm,
	output logic                 flush,             // kill what enters ID_EX
	output logic                 load_use,          // insert one bubble
	output logic                 stall_im_id        // hold fetch and holding register
);

	logic flow_change_ex_dm;                        // flow change one stage later
	logic p0_hit;
	logic p1_hit;

	////////////////////
	// flow change pipe
	////////////////////
	// two instructions behind a taken branch are already fetched
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			flow_change_ex_dm <= 1'b0;
		end else begin
			flow_change_ex_dm <= flow_change_id_ex;
		end
	end

	assign flush = flow_change_id_ex | flow_change_ex_dm |  // both wrong-path slots
		hlt_id_ex | hlt_ex_dm;                               // nothing runs past HLT

	////////////////////
	// load-use detect
	////////////////////
	assign p0_hit = rf_rd.re0 && (rf_rd.p0_addr == wb_id_ex.dst);  // enabled port only
	assign p1_hit = rf_rd.re1 && (rf_rd.p1_addr == wb_id_ex.dst);

	assign load_use = dm_re_id_ex & (p0_hit | p1_hit);  // data not ready until DM

	// sticky halt keeps fetch frozen until reset
	assign stall_im_id = load_use | hlt_id_ex;

endmodule

/* design/id_stage.sv */
module id_stage (
	input  logic                 clk,
	input  logic                 rst_n,
	input  decode_pkg::instr_t   instr,             // held by IM while stalled
	input  logic                 zr_ex_dm,
	input  logic                 flow_change_id_ex,
	output decode_pkg::rf_read_t rf_rd,
	output decode_pkg::ex_ctrl_t ex_ctrl,
	output decode_pkg::dm_ctrl_t dm_ctrl,
	output decode_pkg::wb_ctrl_t wb,
	output decode_pkg::byp_t     byp,
	output logic                 hlt_dm_wb,
	output logic                 stall_im_id
);

	decode_pkg::id_ctrl_t id_ctrl;              // decode to ID_EX
	decode_pkg::wb_ctrl_t wb_id_ex;
	decode_pkg::wb_ctrl_t wb_ex_dm;
	logic                 dm_re_id_ex;
	logic                 hlt_id_ex;
	logic                 hlt_ex_dm;
	logic                 flush;
	logic                 load_use;

	instr_decode u_decode (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr       (instr),
		.stall_im_id (stall_im_id),
		.rf_rd       (rf_rd),
		.id_ctrl     (id_ctrl)
	);

	hazard_unit u_hazard (
		.clk               (clk),
		.rst_n             (rst_n),
		.flow_change_id_ex (flow_change_id_ex),
		.rf_rd             (rf_rd),
		.wb_id_ex          (wb_id_ex),
		.dm_re_id_ex       (dm_re_id_ex),
		.hlt_id_ex         (hlt_id_ex),
		.hlt_ex_dm         (hlt_ex_dm),
		.flush             (flush),
		.load_use          (load_use),
		.stall_im_id       (stall_im_id)
	);

	pipe_ctrl u_pipe (
		.clk         (clk),
		.rst_n       (rst_n),
		.id_ctrl     (id_ctrl),
		.flush       (flush),
		.load_use    (load_use),
		.zr_ex_dm    (zr_ex_dm),
		.ex_ctrl     (ex_ctrl),
		.dm_ctrl     (dm_ctrl),
		.wb_id_ex    (wb_id_ex),
		.wb_ex_dm    (wb_ex_dm),
		.wb          (wb),
		.dm_re_id_ex (dm_re_id_ex),
		.hlt_id_ex   (hlt_id_ex),
		.hlt_ex_dm   (hlt_ex_dm),
		.hlt_dm_wb   (hlt_dm_wb)
	);

	bypass_ctrl u_bypass (
		.clk      (clk),
		.rst_n    (rst_n),
		.rf_rd    (rf_rd),
		.wb_id_ex (wb_id_ex),
		.wb_ex_dm (wb_ex_dm),
		.byp      (byp)
	);

endmodule

/* design/instr_decode.sv */
module instr_decode (
	input  logic                 clk,
	input  logic                 rst_n,
	input  decode_pkg::instr_t   instr,        // straight from IM
	input  logic                 stall_im_id,  // hold the current word
	output decode_pkg::rf_read_t rf_rd,        // register file read controls
	output decode_pkg::id_ctrl_t id_ctrl       // everything ID_EX needs
);

	decode_pkg::instr_t instr_im_id;           // holding register

	////////////////////
	// holding register
	////////////////////
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			instr_im_id <= decode_pkg::RESET_INSTR;    // harmless LLB R0 #0
		end else if (!stall_im_id) begin
			instr_im_id <= instr;
		end
	end

	////////////////////
	// opcode decode
	////////////////////
	// defaults cover the common register form and each opcode overrides
	always_comb begin
		rf_rd.re0     = 1'b0;
		rf_rd.re1     = 1'b0;
		rf_rd.p0_addr = instr_im_id.r.p0;
		rf_rd.p1_addr = instr_im_id.r.p1;

		id_ctrl            = '0;
		id_ctrl.ex.alu_func = decode_pkg::ADD;
		id_ctrl.ex.src0sel  = decode_pkg::RF2SRC0;
		id_ctrl.ex.src1sel  = decode_pkg::RF2SRC1;
		id_ctrl.ex.cc       = instr_im_id.b.cc;     // only meaningful for B
		id_ctrl.ex.imm      = instr_im_id.b.offset;
		id_ctrl.wb.dst      = instr_im_id.r.dst;

		case (instr_im_id.r.opcode)
			decode_pkg::OPC_ADD, decode_pkg::OPC_SUB: begin
				rf_rd.re0         = 1'b1;
				rf_rd.re1         = 1'b1;
				id_ctrl.wb.rf_we  = 1'b1;
				id_ctrl.ex.clk_z  = 1'b1;
				id_ctrl.ex.clk_nv = 1'b1;
				if (instr_im_id.r.opcode == decode_pkg::OPC_SUB)
					id_ctrl.ex.alu_func = decode_pkg::SUB;
			end
			decode_pkg::OPC_ADDZ: begin
				rf_rd.re0         = 1'b1;
				rf_rd.re1         = 1'b1;
				id_ctrl.wb.rf_we  = 1'b1;              // may be knocked down at EX_DM
				id_ctrl.ex.clk_z  = 1'b1;
				id_ctrl.ex.clk_nv = 1'b1;
				id_ctrl.cond_ex   = 1'b1;
			end
			decode_pkg::OPC_AND, decode_pkg::OPC_NOR: begin
				rf_rd.re0        = 1'b1;
				rf_rd.re1        = 1'b1;
				id_ctrl.wb.rf_we = 1'b1;
				id_ctrl.ex.clk_z = 1'b1;               // logic ops leave n/v alone
				id_ctrl.ex.alu_func = (instr_im_id.r.opcode == decode_pkg::OPC_AND) ?
					decode_pkg::AND : decode_pkg::NOR;
			end
			decode_pkg::OPC_SLL, decode_pkg::OPC_SRL, decode_pkg::OPC_SRA: begin
				rf_rd.re1        = 1'b1;               // shift amount comes from imm
				id_ctrl.wb.rf_we = 1'b1;
				id_ctrl.ex.clk_z = 1'b1;
				case (instr_im_id.r.opcode)
					decode_pkg::OPC_SLL: id_ctrl.ex.alu_func = decode_pkg::SLL;
					decode_pkg::OPC_SRL: id_ctrl.ex.alu_func = decode_pkg::SRL;
					default:             id_ctrl.ex.alu_func = decode_pkg::SRA;
				endcase
			end
			decode_pkg::OPC_LW: begin
				rf_rd.re1          = 1'b1;             // address base
				id_ctrl.ex.src0sel = decode_pkg::IMM2SRC0;
				id_ctrl.wb.rf_we   = 1'b1;
				id_ctrl.dm_re      = 1'b1;
			end
			decode_pkg::OPC_SW: begin
				rf_rd.re0          = 1'b1;             // store data
				rf_rd.re1          = 1'b1;             // address base
				rf_rd.p0_addr      = instr_im_id.r.dst;  // store data named in dst slot
				id_ctrl.ex.src0sel = decode_pkg::IMM2SRC0;
				id_ctrl.dm_we      = 1'b1;
			end
			decode_pkg::OPC_LHB: begin
				rf_rd.re0           = 1'b1;            // keep the low byte of dst
				rf_rd.p0_addr       = instr_im_id.r.dst;
				id_ctrl.ex.src1sel  = decode_pkg::IMM2SRC1;
				id_ctrl.ex.alu_func = decode_pkg::LHB;
				id_ctrl.wb.rf_we    = 1'b1;
			end
			decode_pkg::OPC_LLB: begin
				rf_rd.re0          = 1'b1;             // zero plus imm
				rf_rd.p0_addr      = decode_pkg::ZERO_REG;
				id_ctrl.ex.src1sel = decode_pkg::IMM2SRC1;
				id_ctrl.wb.rf_we   = 1'b1;
			end
			decode_pkg::OPC_BR: begin
				id_ctrl.ex.src0sel  = decode_pkg::IMM_BR2SRC0;
				id_ctrl.ex.src1sel  = decode_pkg::NPC2SRC1;
				id_ctrl.ex.br_instr = 1'b1;
			end
			decode_pkg::OPC_JAL: begin
				id_ctrl.ex.src0sel = decode_pkg::IMM_JMP2SRC0;
				id_ctrl.ex.src1sel = decode_pkg::NPC2SRC1;
				id_ctrl.ex.jmp_imm = 1'b1;
				id_ctrl.wb.rf_we   = 1'b1;             // next pc into link reg
				id_ctrl.wb.dst     = decode_pkg::LINK_REG;
			end
			decode_pkg::OPC_JR: begin
				rf_rd.re0          = 1'b1;             // zero plus target register
				rf_rd.p0_addr      = decode_pkg::ZERO_REG;
				rf_rd.re1          = 1'b1;
				id_ctrl.ex.jmp_reg = 1'b1;
			end
			decode_pkg::OPC_HLT: begin
				id_ctrl.hlt = 1'b1;
			end
			decode_pkg::OPC_ADDI: begin
				rf_rd.re1          = 1'b1;
				id_ctrl.ex.src0sel = decode_pkg::IMM2SRC0_6BZE;
				id_ctrl.wb.rf_we   = 1'b1;
				id_ctrl.ex.clk_z   = 1'b1;
				id_ctrl.ex.clk_nv  = 1'b1;
			end
			default: ;                                 // unused codes run as nop
		endcase
	end

endmodule

/* design/pipe_ctrl.sv */
module pipe_ctrl (
	input  logic                 clk,
	input  logic                 rst_n,
	input  decode_pkg::id_ctrl_t id_ctrl,     // decode of holding register
	input  logic                 flush,
	input  logic                 load_use,
	input  logic                 zr_ex_dm,    // ALU zero flag for ADDZ
	output decode_pkg::ex_ctrl_t ex_ctrl,     // ID_EX controls
	output decode_pkg::dm_ctrl_t dm_ctrl,     // EX_DM controls
	output decode_pkg::wb_ctrl_t wb_id_ex,
	output decode_pkg::wb_ctrl_t wb_ex_dm,
	output decode_pkg::wb_ctrl_t wb,          // DM_WB register write
	output logic                 dm_re_id_ex,
	output logic                 hlt_id_ex,
	output logic                 hlt_ex_dm,
	output logic                 hlt_dm_wb    // register dump trigger
);

	decode_pkg::ex_ctrl_t ex_nxt;             // ex controls after kills
	decode_pkg::wb_ctrl_t wb_nxt;
	logic                 kill;               // flush or bubble
	logic                 dm_we_id_ex;
	logic                 cond_ex_id_ex;      // ADDZ in EX

	assign kill = flush | load_use;

	always_comb begin
		ex_nxt          = id_ctrl.ex;
		ex_nxt.br_instr = id_ctrl.ex.br_instr & ~flush;
		ex_nxt.jmp_imm  = id_ctrl.ex.jmp_imm & ~flush;
		ex_nxt.jmp_reg  = id_ctrl.ex.jmp_reg & ~flush;
		ex_nxt.clk_z    = id_ctrl.ex.clk_z & ~kill;    // a bubble must not touch flags
		ex_nxt.clk_nv   = id_ctrl.ex.clk_nv & ~kill;
		wb_nxt          = id_ctrl.wb;
		wb_nxt.rf_we    = id_ctrl.wb.rf_we & ~kill;
	end

	////////////////////
	// ID_EX
	////////////////////
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			ex_ctrl       <= '0;
			wb_id_ex      <= '0;
			dm_re_id_ex   <= 1'b0;
			dm_we_id_ex   <= 1'b0;
			cond_ex_id_ex <= 1'b0;
		end else begin
			ex_ctrl       <= ex_nxt;
			wb_id_ex      <= wb_nxt;
			dm_re_id_ex   <= id_ctrl.dm_re & ~load_use;  // else a load on its own dst locks up
			dm_we_id_ex   <= id_ctrl.dm_we & ~kill;
			cond_ex_id_ex <= id_ctrl.cond_ex;
		end
	end

	////////////////////
	// EX_DM
	////////////////////
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			wb_ex_dm <= '0;
			dm_ctrl  <= '0;
		end else begin
			wb_ex_dm.rf_we  <= wb_id_ex.rf_we & ~(cond_ex_id_ex & ~zr_ex_dm);  // ADDZ
			wb_ex_dm.dst    <= wb_id_ex.dst;
			dm_ctrl.dm_re   <= dm_re_id_ex;
			dm_ctrl.dm_we   <= dm_we_id_ex;
			dm_ctrl.jmp_imm <= ex_ctrl.jmp_imm;
		end
	end

	////////////////////
	// DM_WB and halt chain
	////////////////////
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			wb        <= '0;
			hlt_id_ex <= 1'b0;
			hlt_ex_dm <= 1'b0;
			hlt_dm_wb <= 1'b0;
		end else begin
			wb        <= wb_ex_dm;
			hlt_id_ex <= hlt_id_ex | (id_ctrl.hlt & ~flush);  // sticky once seen
			hlt_ex_dm <= hlt_id_ex;
			hlt_dm_wb <= hlt_ex_dm;
		end
	end

endmodule

/* id_stage.f */
design/decode_pkg.sv
design/instr_decode.sv
design/hazard_unit.sv
design/pipe_ctrl.sv
design/bypass_ctrl.sv
design/id_stage.sv
tests/id_stage_chk.sv
tests/id_stage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the id_stage testbench with Verilator.
# The run passes only if the log holds the pass message.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f id_stage.f --top-module id_stage_tb \
	&& ./obj_dir/Vid_stage_tb > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -q -F '*** PASSED ***' sim.log && exit 0 || exit 1

/* tests/id_stage_chk.sv */
module id_stage_chk (
	input logic                 clk,
	input logic                 rst_n,
	input decode_pkg::rf_read_t rf_rd,
	input decode_pkg::byp_t     byp,
	input decode_pkg::dm_ctrl_t dm_ctrl,
	input logic                 hlt_dm_wb,
	input logic                 stall_im_id
);

	// rf_rd only follows the holding register, so a frozen word keeps it steady
	a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
		stall_im_id |=> (rf_rd == $past(rf_rd)))
		else $error("holding register moved during stall");

	a_no_byp_r0_p0: assert property (@(posedge clk) disable iff (!rst_n)
		(rf_rd.p0_addr == decode_pkg::ZERO_REG) |=> !(byp.byp0_ex || byp.byp0_dm))
		else $error("port 0 bypass set for register 0");

	a_no_byp_r0_p1: assert property (@(posedge clk) disable iff (!rst_n)
		(rf_rd.p1_addr == decode_pkg::ZERO_REG) |=> !(byp.byp1_ex || byp.byp1_dm))
		else $error("port 1 bypass set for register 0");

	a_dm_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(dm_ctrl.dm_re && dm_ctrl.dm_we))
		else $error("dm read and write in the same cycle");

	a_hlt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
		hlt_dm_wb |=> hlt_dm_wb)
		else $error("halt dropped before reset");

endmodule

bind id_stage id_stage_chk u_chk (
	.clk         (clk),
	.rst_n       (rst_n),
	.rf_rd       (rf_rd),
	.byp         (byp),
	.dm_ctrl     (dm_ctrl),
	.hlt_dm_wb   (hlt_dm_wb),
	.stall_im_id (stall_im_id)
);

/* tests/id_stage_tb.sv */
module id_stage_tb;

	localparam int N_TESTS = 6;
	localparam logic [47:0] NOP_WORD = {6'b0, 6'b111111, 36'b0};   // unused opcode

	logic                 clk;
	logic                 rst_n;
	decode_pkg::instr_t   instr;
	logic                 zr_ex_dm;
	logic                 flow_change_id_ex;
	decode_pkg::rf_read_t rf_rd;
	decode_pkg::ex_ctrl_t ex_ctrl;
	decode_pkg::dm_ctrl_t dm_ctrl;
	decode_pkg::wb_ctrl_t wb;
	decode_pkg::byp_t     byp;
	logic                 hlt_dm_wb;
	logic                 stall_im_id;
	int                   n_checks;
	int                   n_errors;

	id_stage DUT (.*);

	always #20 clk = ~clk;

	////////////////////
	// helpers
	////////////////////
	task automatic step();
		@(posedge clk);
		#5;                                        // drive and sample clear of the edge
	endtask

	task automatic do_reset();
		rst_n = 1'b0;
		instr = NOP_WORD;
		zr_ex_dm = 1'b1;
		flow_change_id_ex = 1'b0;
		repeat (4) @(posedge clk);
		#5 rst_n = 1'b1;
	endtask

	function automatic logic [5:0] rand_reg();
		logic [31:0] v;
		v = $urandom % 62 + 1;                     // 1..62 so never r0
		return v[5:0];
	endfunction

	function automatic decode_pkg::instr_t make_r(input logic [5:0] opc,
		input logic [5:0] dst, input logic [5:0] p1, input logic [5:0] p0);
		logic [63:0] raw;
		decode_pkg::instr_t i;
		raw = {$urandom, $urandom};
		i = raw[47:0];                             // junk in the unused bits
		i.r.opcode = opc;
		i.r.dst = dst;
		i.r.p1 = p1;
		i.r.p0 = p0;
		return i;
	endfunction

	// expected controls straight from the opcode table
	task automatic expect_decode(input decode_pkg::instr_t i,
		output decode_pkg::rf_read_t r, output decode_pkg::ex_ctrl_t e,
		output decode_pkg::dm_ctrl_t d, output decode_pkg::wb_ctrl_t w);
		r = '0;
		r.p0_addr = i.r.p0;
		r.p1_addr = i.r.p1;
		e = '0;
		e.alu_func = decode_pkg::ADD;
		e.src0sel = decode_pkg::RF2SRC0;
		e.src1sel = decode_pkg::RF2SRC1;
		e.cc = i.b.cc;
		e.imm = i.b.offset;
		d = '0;
		w = '0;
		w.dst = i.r.dst;
		case (i.r.opcode)
			decode_pkg::OPC_ADD, decode_pkg::OPC_ADDZ, decode_pkg::OPC_SUB: begin
				r.re0 = 1'b1;
				r.re1 = 1'b1;
				e.clk_z = 1'b1;
				e.clk_nv = 1'b1;
				w.rf_we = 1'b1;                    // ADDZ too while the zero flag is held high
				if (i.r.opcode == decode_pkg::OPC_SUB) e.alu_func = decode_pkg::SUB;
			end
			decode_pkg::OPC_AND, decode_pkg::OPC_NOR: begin
				r.re0 = 1'b1;
				r.re1 = 1'b1;
				e.clk_z = 1'b1;
				w.rf_we = 1'b1;
				e.alu_func = (i.r.opcode == decode_pkg::OPC_AND) ? decode_pkg::AND
					: decode_pkg::NOR;
			end
			decode_pkg::OPC_SLL, decode_pkg::OPC_SRL, decode_pkg::OPC_SRA: begin
				r.re1 = 1'b1;
				e.clk_z = 1'b1;
				w.rf_we = 1'b1;
				if (i.r.opcode == decode_pkg::OPC_SLL) e.alu_func = decode_pkg::SLL;
				else if (i.r.opcode == decode_pkg::OPC_SRL) e.alu_func = decode_pkg::SRL;
				else e.alu_func = decode_pkg::SRA;
			end
			decode_pkg::OPC_LW: begin
				r.re1 = 1'b1;
				e.src0sel = decode_pkg::IMM2SRC0;
				d.dm_re = 1'b1;
				w.rf_we = 1'b1;
			end
			decode_pkg::OPC_SW: begin
				r.re0 = 1'b1;
				r.re1 = 1'b1;
				r.p0_addr = i.r.dst;
				e.src0sel = decode_pkg::IMM2SRC0;
				d.dm_we = 1'b1;
			end
			decode_pkg::OPC_LHB, decode_pkg::OPC_LLB: begin
				r.re0 = 1'b1;
				r.p0_addr = (i.r.opcode == decode_pkg::OPC_LHB) ? i.r.dst
					: decode_pkg::ZERO_REG;
				e.src1sel = decode_pkg::IMM2SRC1;
				if (i.r.opcode == decode_pkg::OPC_LHB) e.alu_func = decode_pkg::LHB;
				w.rf_we = 1'b1;
			end
			decode_pkg::OPC_BR: begin
				e.br_instr = 1'b1;
				e.src0sel = decode_pkg::IMM_BR2SRC0;
				e.src1sel = decode_pkg::NPC2SRC1;
			end
			decode_pkg::OPC_JAL: begin
				e.jmp_imm = 1'b1;
				e.src0sel = decode_pkg::IMM_JMP2SRC0;
				e.src1sel = decode_pkg::NPC2SRC1;
				d.jmp_imm = 1'b1;
				w.rf_we = 1'b1;
				w.dst = decode_pkg::LINK_REG;
			end
			decode_pkg::OPC_JR: begin
				r.re0 = 1'b1;
				r.re1 = 1'b1;
				r.p0_addr = decode_pkg::ZERO_REG;
				e.jmp_reg = 1'b1;
			end
			decode_pkg::OPC_ADDI: begin
				r.re1 = 1'b1;
				e.src0sel = decode_pkg::IMM2SRC0_6BZE;
				e.clk_z = 1'b1;
				e.clk_nv = 1'b1;
				w.rf_we = 1'b1;
			end
			default: ;                             // HLT and unused codes drive nothing here
		endcase
	endtask

	////////////////////
	// compare tasks
	////////////////////
	task automatic check_rf_rd(input decode_pkg::rf_read_t got, exp, input string what);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("MISMATCH @%0t %s: rf_rd got %h exp %h", $time, what, got, exp);
		end
	endtask

	task automatic check_ex(input decode_pkg::ex_ctrl_t got, exp, input string what);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("MISMATCH @%0t %s: ex_ctrl got %h exp %h", $time, what, got, exp);
		end
	endtask

	task automatic check_dm(input decode_pkg::dm_ctrl_t got, exp, input string what);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("MISMATCH @%0t %s: dm_ctrl got %b exp %b", $time, what, got, exp);
		end
	endtask

	task automatic check_wb(input decode_pkg::wb_ctrl_t got, exp, input string what);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("MISMATCH @%0t %s: wb got %h exp %h", $time, what, got, exp);
		end
	endtask

	task automatic check_byp(input decode_pkg::byp_t got, exp, input string what);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("MISMATCH @%0t %s: byp got %b exp %b", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, exp, input string what);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("MISMATCH @%0t %s: got %b exp %b", $time, what, got, exp);
		end
	endtask

	////////////////////
	// directed tests
	////////////////////
	task automatic test_decode();
		logic [5:0] opcs [0:16];
		decode_pkg::instr_t i;
		decode_pkg::rf_read_t r;
		decode_pkg::ex_ctrl_t e;
		decode_pkg::dm_ctrl_t d;
		decode_pkg::wb_ctrl_t w;
		opcs = '{decode_pkg::OPC_ADD, decode_pkg::OPC_ADDZ, decode_pkg::OPC_SUB,
			decode_pkg::OPC_AND, decode_pkg::OPC_NOR, decode_pkg::OPC_SLL,
			decode_pkg::OPC_SRL, decode_pkg::OPC_SRA, decode_pkg::OPC_LW,
			decode_pkg::OPC_SW, decode_pkg::OPC_LHB, decode_pkg::OPC_LLB,
			decode_pkg::OPC_BR, decode_pkg::OPC_JAL, decode_pkg::OPC_JR,
			decode_pkg::OPC_ADDI, decode_pkg::OPC_HLT};
		do_reset();
		for (int k = 0; k < 17; k++) begin
			i = make_r(opcs[k], rand_reg(), rand_reg(), rand_reg());
			expect_decode(i, r, e, d, w);
			instr = i;
			step();                                // E0
			check_rf_rd(rf_rd, r, "decode rf_rd");
			instr = NOP_WORD;
			step();                                // E1
			check_ex(ex_ctrl, e, "decode ex");
			step();
			check_dm(dm_ctrl, d, "decode dm");
			step();
			check_wb(wb, w, "decode wb");
		end
		do_reset();                                // clears the sticky halt
	endtask

	task automatic test_addz();
		decode_pkg::instr_t i;
		decode_pkg::wb_ctrl_t w;
		for (int z = 0; z < 2; z++) begin
			do_reset();
			i = make_r(decode_pkg::OPC_ADDZ, rand_reg(), rand_reg(), rand_reg());
			instr = i;
			step();
			instr = NOP_WORD;
			step();                                // ADDZ now in EX
			zr_ex_dm = z[0];
			step();                                // EX_DM edge sees the flag
			zr_ex_dm = 1'b1;
			step();
			w.rf_we = z[0];
			w.dst = i.r.dst;
			check_wb(wb, w, "addz write");
		end
	endtask

	task automatic test_load_use();
		logic [5:0] n;
		decode_pkg::instr_t lw;
		decode_pkg::instr_t add;
		decode_pkg::rf_read_t r;
		decode_pkg::ex_ctrl_t e_ld, e_add, e_bub;
		decode_pkg::dm_ctrl_t d_ld, d_add;
		decode_pkg::wb_ctrl_t w_ld, w_add, w_bub;
		do_reset();
		n = rand_reg();
		lw = make_r(decode_pkg::OPC_LW, n, rand_reg(), rand_reg());
		add = make_r(decode_pkg::OPC_ADD, rand_reg(), rand_reg(), n);
		expect_decode(lw, r, e_ld, d_ld, w_ld);
		expect_decode(add, r, e_add, d_add, w_add);
		e_bub = e_add;
		e_bub.clk_z = 1'b0;
		e_bub.clk_nv = 1'b0;
		w_bub = w_add;
		w_bub.rf_we = 1'b0;
		instr = lw;
		step();
		instr = add;
		step();                                    // load in EX with ADD in decode
		check_flag(stall_im_id, 1'b1, "load-use stall");
		check_ex(ex_ctrl, e_ld, "load ex");
		step();                                    // ADD held while a bubble enters EX
		check_flag(stall_im_id, 1'b0, "stall one cycle only");
		check_ex(ex_ctrl, e_bub, "bubble ex");
		check_dm(dm_ctrl, d_ld, "load dm");
		instr = NOP_WORD;
		step();
		check_flag(stall_im_id, 1'b0, "no second stall");
		check_ex(ex_ctrl, e_add, "late add ex");
		check_dm(dm_ctrl, '0, "bubble dm");
		check_wb(wb, w_ld, "load wb");
		step();
		check_dm(dm_ctrl, d_add, "late add dm");
		check_wb(wb, w_bub, "bubble wb");
		step();
		check_wb(wb, w_add, "late add wb");
	endtask

	task automatic test_bypass();
		logic [5:0] n;
		logic [5:0] m;
		decode_pkg::byp_t exp;
		do_reset();
		n = rand_reg();
		m = n + 6'd1;                              // differs from n and from r0
		instr = make_r(decode_pkg::OPC_ADD, n, rand_reg(), rand_reg());
		step();
		instr = make_r(decode_pkg::OPC_ADD, rand_reg(), m, n);
		step();
		instr = NOP_WORD;
		step();
		exp = '0;
		exp.byp0_ex = 1'b1;
		check_byp(byp, exp, "bypass from ID_EX");
		do_reset();
		instr = make_r(decode_pkg::OPC_ADD, n, rand_reg(), rand_reg());
		step();
		instr = NOP_WORD;
		step();
		instr = make_r(decode_pkg::OPC_ADD, rand_reg(), n, m);
		step();
		instr = NOP_WORD;
		step();
		exp = '0;
		exp.byp1_dm = 1'b1;
		check_byp(byp, exp, "bypass from EX_DM");
		do_reset();
		instr = make_r(decode_pkg::OPC_ADD, decode_pkg::ZERO_REG, rand_reg(), rand_reg());
		step();
		instr = make_r(decode_pkg::OPC_ADD, rand_reg(), 6'd0, 6'd0);
		step();
		instr = NOP_WORD;
		step();
		check_byp(byp, '0, "no bypass on r0 ex");
		step();
		check_byp(byp, '0, "no bypass on r0 dm");
	endtask

	task automatic test_flush();
		decode_pkg::instr_t j1, s2, j3;
		decode_pkg::rf_read_t r;
		decode_pkg::ex_ctrl_t e1, e2, e3;
		decode_pkg::dm_ctrl_t d1, d2, d3;
		decode_pkg::wb_ctrl_t w1, w2, w3;
		do_reset();
		j1 = make_r(decode_pkg::OPC_JAL, rand_reg(), rand_reg(), rand_reg());
		s2 = make_r(decode_pkg::OPC_SW, rand_reg(), rand_reg(), rand_reg());
		j3 = make_r(decode_pkg::OPC_JAL, rand_reg(), rand_reg(), rand_reg());
		expect_decode(j1, r, e1, d1, w1);
		expect_decode(s2, r, e2, d2, w2);
		expect_decode(j3, r, e3, d3, w3);
		e1.jmp_imm = 1'b0;                         // killed on the pulse edge
		w1.rf_we = 1'b0;
		instr = j1;
		step();
		instr = s2;
		flow_change_id_ex = 1'b1;
		step();
		flow_change_id_ex = 1'b0;
		instr = j3;
		check_ex(ex_ctrl, e1, "flushed jal ex");
		step();
		instr = NOP_WORD;
		check_ex(ex_ctrl, e2, "flushed sw ex");
		check_dm(dm_ctrl, '0, "flushed jal dm");
		step();
		check_ex(ex_ctrl, e3, "third instr ex");
		check_dm(dm_ctrl, '0, "flushed sw dm");
		check_wb(wb, w1, "flushed jal wb");
		step();
		check_dm(dm_ctrl, d3, "third instr dm");
		check_wb(wb, w2, "flushed sw wb");
		step();
		check_wb(wb, w3, "third instr wb");
	endtask

	task automatic test_halt();
		decode_pkg::instr_t add;
		decode_pkg::rf_read_t r;
		decode_pkg::ex_ctrl_t e;
		decode_pkg::dm_ctrl_t d;
		decode_pkg::wb_ctrl_t w;
		do_reset();
		add = make_r(decode_pkg::OPC_ADD, rand_reg(), rand_reg(), rand_reg());
		expect_decode(add, r, e, d, w);
		e.clk_z = 1'b0;
		e.clk_nv = 1'b0;
		w.rf_we = 1'b0;
		instr = make_r(decode_pkg::OPC_HLT, rand_reg(), rand_reg(), rand_reg());
		step();
		check_flag(stall_im_id, 1'b0, "stall before halt in ID_EX");
		instr = add;
		step();
		check_flag(stall_im_id, 1'b1, "halt stall");
		check_flag(hlt_dm_wb, 1'b0, "halt too early");
		instr = NOP_WORD;                          // frozen holding register ignores this
		step();
		check_rf_rd(rf_rd, r, "held word after halt");
		check_ex(ex_ctrl, e, "after halt ex");
		check_flag(hlt_dm_wb, 1'b0, "halt too early");
		step();
		check_flag(hlt_dm_wb, 1'b1, "halt at DM_WB");
		repeat (4) begin
			step();
			check_flag(stall_im_id, 1'b1, "halt stall sticky");
			check_flag(hlt_dm_wb, 1'b1, "halt sticky");
			check_rf_rd(rf_rd, r, "held word after halt");
			check_wb(wb, w, "after halt wb");
		end
		do_reset();
		check_flag(hlt_dm_wb, 1'b0, "halt cleared by reset");
		check_flag(stall_im_id, 1'b0, "stall cleared by reset");
	endtask

	////////////////////
	// run control
	////////////////////
	initial begin
		#(N_TESTS * 40 * 40);
		$display("timeout: tests did not finish in time");
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		instr = NOP_WORD;
		zr_ex_dm = 1'b1;
		flow_change_id_ex = 1'b0;
		n_checks = 0;
		n_errors = 0;
		void'($urandom(93154));
		test_decode();
		test_addz();
		test_load_use();
		test_bypass();
		test_flush();
		test_halt();
		$display("checks: %0d  errors: %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule
